/* source/ps2Pkg.sv */
`default_nettype none

package ps2Pkg;

	////////////////////
	// Line filter
	////////////////////

	// Equal samples needed before a filtered line flips
	localparam int filterLen = 4;

	////////////////////
	// Deframer
	////////////////////

	// Cycles without a clock edge before a started frame is dropped
	localparam logic [10:0] idleTimeout = 11'd1024;

	// One PS/2 frame listed MSB first
	// Start arrives first on the wire and ends up in bit 0
	typedef struct packed {
		logic       stop;
		logic       parity;
		logic [7:0] data;
		logic       start;
	} ps2Frame;

	////////////////////
	// Scan-code set 2
	////////////////////

	// Extended-key prefix
	localparam logic [7:0] prefixExtended = 8'hE0;
	// Break (key release) prefix
	localparam logic [7:0] prefixRelease = 8'hF0;

	// Decoded key event handed to the user
	typedef struct packed {
		logic       extended;
		logic       released;
		logic [7:0] code;
	} keyEvent;

endpackage

`default_nettype wire

/* source/ps2LineFilter.sv */
`default_nettype none

module ps2LineFilter (
	input  logic clk,
	input  logic rstN,
	input  logic ps2c,
	input  logic ps2d,
	output logic ps2cFall,
	output logic ps2dClean
);
	import ps2Pkg::*;

	// Bit 0 is the clock line, bit 1 the data line
	logic [1:0] pinIn;
	logic [1:0] clean;
	// Filtered clock one cycle back
	logic       cleanCPrev;

	assign pinIn = {ps2d, ps2c};

	for (genvar i = 0; i < 2; i++) begin : gLine
		logic                         syncA;
		logic                         syncB;
		logic                         lineClean;
		logic [$clog2(filterLen)-1:0] agreeCnt;

		// Two-flop synchronizer, then the glitch filter
		// Counter runs while the synced line disagrees with the filtered one
		always_ff @(posedge clk or negedge rstN) begin
			if (!rstN) begin
				// Lines idle high
				syncA     <= 1'b1;
				syncB     <= 1'b1;
				lineClean <= 1'b1;
				agreeCnt  <= '0;
			end else begin
				syncA <= pinIn[i];
				syncB <= syncA;
				if (syncB == lineClean) begin
					// Any agreement restarts the count
					agreeCnt <= '0;
				end else if (int'(agreeCnt) == filterLen - 1) begin
					lineClean <= syncB;
					agreeCnt  <= '0;
				end else begin
					agreeCnt <= agreeCnt + 1'b1;
				end
			end
		end

		assign clean[i] = lineClean;
	end

	assign ps2dClean = clean[1];

	// Edge detect on filtered clock
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			cleanCPrev <= 1'b1;
		end else begin
			cleanCPrev <= clean[0];
		end
	end

	// One cycle per filtered falling edge
	assign ps2cFall = cleanCPrev & ~clean[0];

endmodule

`default_nettype wire

/* source/ps2Deframer.sv */
`default_nettype none

module ps2Deframer (
	input  logic       clk,
	input  logic       rstN,
	input  logic       ps2cFall,
	input  logic       ps2dClean,
	output logic [7:0] byteData,
	output logic       byteEnable,
	output logic       frameError
);
	import ps2Pkg::*;

	ps2Frame     shiftReg;
	// Frame as it looks after the current bit is shifted in
	ps2Frame     nextFrame;
	// Bits received so far in this frame
	logic [3:0]  bitCount;
	// Cycles since the last clock edge
	logic [10:0] idleCount;
	logic        frameOk;
	logic        lastBit;
	logic        timedOut;

	////////////////////
	// Shift and check
	////////////////////

	// LSB first, so new bits enter at the top
	assign nextFrame = {ps2dClean, shiftReg[10:1]};

	// Start low, odd parity over data plus parity bit, stop high
	assign frameOk = (nextFrame.start == 1'b0)
		&& (^{nextFrame.data, nextFrame.parity} == 1'b1)
		&& (nextFrame.stop == 1'b1);

	// Stop bit edge
	assign lastBit = ps2cFall && (bitCount == 4'd10);

	// Frame started but the keyboard went quiet
	assign timedOut = !ps2cFall && (bitCount != 4'd0)
		&& (idleCount == idleTimeout - 11'd1);

	always_ff @(posedge clk) begin
		if (ps2cFall) begin
			shiftReg <= nextFrame;
		end
	end

	// Stable from byteEnable until the next frame starts
	assign byteData = shiftReg.data;

	////////////////////
	// Bit counter
	////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			bitCount   <= '0;
			idleCount  <= '0;
			byteEnable <= 1'b0;
			frameError <= 1'b0;
		end else begin
			byteEnable <= lastBit && frameOk;
			frameError <= (lastBit && !frameOk) || timedOut;
			if (ps2cFall) begin
				idleCount <= '0;
				if (lastBit) begin
					bitCount <= '0;
				end else begin
					bitCount <= bitCount + 4'd1;
				end
			end else if (timedOut) begin
				// Abandon the partial frame
				bitCount  <= '0;
				idleCount <= '0;
			end else if (bitCount != 4'd0) begin
				idleCount <= idleCount + 11'd1;
			end
		end
	end

	// Good byte and error never reported for the same frame
	aByteOrError: assert property (@(posedge clk) disable iff (!rstN)
		!(byteEnable && frameError))
		else $error("byteEnable and frameError high together");

	// Counter wraps at the stop bit
	aBitCountRange: assert property (@(posedge clk) disable iff (!rstN)
		bitCount <= 4'd10)
		else $error("bitCount out of range");

endmodule

`default_nettype wire

/* source/scanDecoder.sv */
`default_nettype none

module scanDecoder (
	input  logic            clk,
	input  logic            rstN,
	input  logic [7:0]      byteData,
	input  logic            byteEnable,
	input  logic            frameError,
	input  logic            keyReady,
	output ps2Pkg::keyEvent key,
	output logic            keyValid,
	output logic            overrun
);
	import ps2Pkg::*;

	// Pending prefixes
	logic extFlag;
	logic relFlag;
	logic isExtended;
	logic isRelease;
	// Byte that completes an event
	logic isCode;
	// Holding register full and not leaving this cycle
	logic slotBusy;

	assign isExtended = byteEnable && (byteData == prefixExtended);
	assign isRelease  = byteEnable && (byteData == prefixRelease);
	assign isCode     = byteEnable && !isExtended && !isRelease;
	assign slotBusy   = keyValid && !keyReady;

	////////////////////
	// Prefix flags
	////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			extFlag <= 1'b0;
			relFlag <= 1'b0;
		end else if (frameError || isCode) begin
			// Consumed by the code byte, or lost with a bad frame
			extFlag <= 1'b0;
			relFlag <= 1'b0;
		end else begin
			if (isExtended) begin
				extFlag <= 1'b1;
			end
			if (isRelease) begin
				relFlag <= 1'b1;
			end
		end
	end

	////////////////////
	// Event register
	////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			keyValid <= 1'b0;
			overrun  <= 1'b0;
		end else begin
			// Keyboard cannot wait, so a busy slot drops the byte
			overrun <= isCode && slotBusy;
			if (isCode && !slotBusy) begin
				keyValid <= 1'b1;
			end else if (keyReady) begin
				keyValid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (isCode && !slotBusy) begin
			key.extended <= extFlag;
			key.released <= relFlag;
			key.code     <= byteData;
		end
	end

	// Held event stays put until taken
	aKeyHold: assert property (@(posedge clk) disable iff (!rstN)
		keyValid && !keyReady |=> keyValid && $stable(key))
		else $error("key changed before transfer");

endmodule

`default_nettype wire

/* source/ps2Receiver.sv */
`default_nettype none

module ps2Receiver (
	input  logic            clk,
	input  logic            rstN,
	input  logic            ps2c,
	input  logic            ps2d,
	output ps2Pkg::keyEvent key,
	output logic            keyValid,
	input  logic            keyReady,
	output logic            frameError,
	output logic            overrun
);

	// Filter to deframer
	logic       ps2cFall;
	logic       ps2dClean;
	// Deframer to decoder as a one-cycle strobe
	logic [7:0] byteData;
	logic       byteEnable;

	////////////////////
	// Line front end
	////////////////////

	ps2LineFilter lineFilter (
		.clk      (clk),
		.rstN     (rstN),
		.ps2c     (ps2c),
		.ps2d     (ps2d),
		.ps2cFall (ps2cFall),
		.ps2dClean(ps2dClean)
	);

	////////////////////
	// Frame and decode
	////////////////////

	ps2Deframer deframer (
		.clk       (clk),
		.rstN      (rstN),
		.ps2cFall  (ps2cFall),
		.ps2dClean (ps2dClean),
		.byteData  (byteData),
		.byteEnable(byteEnable),
		.frameError(frameError)
	);

	// frameError also flushes pending prefixes
	scanDecoder decoder (
		.clk       (clk),
		.rstN      (rstN),
		.byteData  (byteData),
		.byteEnable(byteEnable),
		.frameError(frameError),
		.keyReady  (keyReady),
		.key       (key),
		.keyValid  (keyValid),
		.overrun   (overrun)
	);

endmodule

`default_nettype wire

/* tb/ps2ReceiverTb.sv */
`default_nettype none

module ps2ReceiverTb;
	import ps2Pkg::*;

	// PS/2 half-bit in clk cycles
	localparam int halfBit = 20;
	localparam int numPlain = 24;
	// Plain codes plus the directed frames of the other tests
	localparam int numFrames = numPlain + 17;
	// Eleven bits plus the idle gap after each frame
	localparam int frameCycles = 11 * 2 * halfBit + 2 * halfBit;
	localparam int cycleLimit = numFrames * frameCycles + 2 * int'(idleTimeout) + 4000;

	logic        clk;
	logic        rstN;
	logic        ps2c;
	logic        ps2d;
	logic        keyReady;
	keyEvent     key;
	logic        keyValid;
	logic        frameError;
	logic        overrun;

	logic [31:0] lfsrState;
	// Forces keyReady low
	logic        holdReady;
	// Model queue of predicted events
	keyEvent     expQ[$];
	keyEvent     wantKey;
	string       testName;
	int          errors;
	int          errSeen;
	int          ovrSeen;
	int          cycleCount;

	ps2Receiver uut (
		.clk       (clk),
		.rstN      (rstN),
		.ps2c      (ps2c),
		.ps2d      (ps2d),
		.key       (key),
		.keyValid  (keyValid),
		.keyReady  (keyReady),
		.frameError(frameError),
		.overrun   (overrun)
	);

	always #20 clk = ~clk;

	////////////////////
	// Random numbers
	////////////////////

	// Fibonacci taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			r = {r[30:0], lfsrState[0]};
		end
		return r;
	endfunction

	// Random code that is neither prefix
	function automatic logic [7:0] plainCode();
		logic [7:0] c;
		c = 8'(randBits(8));
		if (c == prefixExtended || c == prefixRelease) begin
			c[0] = 1'b1;
		end
		return c;
	endfunction

	////////////////////
	// Checks and model
	////////////////////

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic expectKey(input logic ext, input logic rel, input logic [7:0] code);
		keyEvent ev;
		ev.extended = ext;
		ev.released = rel;
		ev.code     = code;
		expQ.push_back(ev);
	endtask

	// Inputs change 2 units after the edge
	// keyReady random unless held
	task automatic waitCycle();
		@(posedge clk);
		#2;
		keyReady = !holdReady && (randBits(1) != 32'd0);
	endtask

	////////////////////
	// PS/2 device
	////////////////////

	// Sends the first nBits bits of a frame
	// All 11 for a whole frame
	task automatic sendFrame(input logic [7:0] data, input logic badParity,
		input logic badStop, input int nBits, input logic glitch);
		ps2Frame     frame;
		logic [10:0] bits;
		int          glitchAt;
		int          glitchLen;
		frame.start  = 1'b0;
		frame.data   = data;
		frame.parity = ~(^data) ^ badParity;
		frame.stop   = ~badStop;
		bits = frame;
		glitchAt = glitch ? int'(randBits(4)) % 11 : -1;
		glitchLen = 1 + int'(randBits(1));
		for (int i = 0; i < nBits; i++) begin
			ps2d = bits[i];
			// Clock high half with an optional short low spike
			for (int c = 0; c < halfBit; c++) begin
				ps2c = !(i == glitchAt && c >= 8 && c < 8 + glitchLen);
				waitCycle();
			end
			ps2c = 1'b0;
			repeat (halfBit) waitCycle();
			ps2c = 1'b1;
		end
		ps2d = 1'b1;
		repeat (2 * halfBit) waitCycle();
	endtask

	task automatic sendByte(input logic [7:0] data);
		sendFrame(data, 1'b0, 1'b0, 11, 1'b0);
	endtask

	task automatic waitDrain();
		while (expQ.size() != 0) begin
			waitCycle();
		end
		repeat (4) waitCycle();
	endtask

	// Transfers, error and overrun pulses
	always @(posedge clk) begin
		if (rstN) begin
			if (frameError) begin
				errSeen++;
			end
			if (overrun) begin
				ovrSeen++;
			end
			if (keyValid && keyReady) begin
				if (expQ.size() == 0) begin
					$display("Unexpected event %h during %s", key, testName);
					errors++;
				end else begin
					wantKey = expQ.pop_front();
					checkValue(testName, {22'd0, wantKey}, {22'd0, key});
				end
			end
		end
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("TEST FAIL");
			$finish;
		end
	end

	initial begin
		logic [7:0] code;
		logic [7:0] other;
		int         nBits;
		keyEvent    held;
		clk        = 1'b0;
		rstN       = 1'b0;
		ps2c       = 1'b1;
		ps2d       = 1'b1;
		keyReady   = 1'b0;
		holdReady  = 1'b1;
		lfsrState  = 32'hb7c2;
		errors     = 0;
		errSeen    = 0;
		ovrSeen    = 0;
		cycleCount = 0;

		// Outputs quiet in and after reset
		testName = "reset idle";
		repeat (8) begin
			waitCycle();
			checkValue(testName, 32'd0, {29'd0, keyValid, frameError, overrun});
		end
		rstN = 1'b1;
		holdReady = 1'b0;
		repeat (10) begin
			waitCycle();
			checkValue(testName, 32'd0, {29'd0, keyValid, frameError, overrun});
		end

		testName = "plain codes";
		repeat (numPlain) begin
			code = plainCode();
			expectKey(1'b0, 1'b0, code);
			sendFrame(code, 1'b0, 1'b0, 11, randBits(1) != 32'd0);
		end
		waitDrain();

		testName = "prefixes";
		code = plainCode();
		expectKey(1'b0, 1'b1, code);
		sendByte(prefixRelease);
		sendByte(code);
		code = plainCode();
		expectKey(1'b1, 1'b0, code);
		sendByte(prefixExtended);
		sendByte(code);
		code = plainCode();
		expectKey(1'b1, 1'b1, code);
		sendByte(prefixExtended);
		sendByte(prefixRelease);
		sendByte(code);
		waitDrain();

		// Bad frame drops the pending prefix
		testName = "bad frames";
		sendByte(prefixExtended);
		sendFrame(plainCode(), 1'b1, 1'b0, 11, 1'b0);
		code = plainCode();
		expectKey(1'b0, 1'b0, code);
		sendByte(code);
		sendByte(prefixRelease);
		sendFrame(plainCode(), 1'b0, 1'b1, 11, 1'b0);
		code = plainCode();
		expectKey(1'b0, 1'b0, code);
		sendByte(code);
		waitDrain();
		checkValue("bad frame errors", 32'd2, errSeen);

		testName = "overrun";
		holdReady = 1'b1;
		code = plainCode();
		other = plainCode();
		held.extended = 1'b0;
		held.released = 1'b0;
		held.code     = code;
		expectKey(1'b0, 1'b0, code);
		sendByte(code);
		checkValue("overrun first key", {22'd0, held}, {22'd0, key});
		sendByte(other);
		checkValue("overrun held valid", 32'd1, {31'd0, keyValid});
		checkValue("overrun held key", {22'd0, held}, {22'd0, key});
		checkValue("overrun count", 32'd1, ovrSeen);
		// Second code is lost, so nothing follows the first
		holdReady = 1'b0;
		waitDrain();
		repeat (100) waitCycle();

		testName = "truncated frame";
		nBits = 1 + int'(randBits(4)) % 10;
		sendFrame(plainCode(), 1'b0, 1'b0, nBits, 1'b0);
		// Last clock edge lies about 60 cycles back, still inside the idle window
		repeat (int'(idleTimeout) - 100) waitCycle();
		checkValue("truncated early errors", 32'd2, errSeen);
		repeat (200) waitCycle();
		checkValue("truncated errors", 32'd3, errSeen);
		code = plainCode();
		expectKey(1'b0, 1'b0, code);
		sendByte(code);
		waitDrain();
		checkValue("final overruns", 32'd1, ovrSeen);
		checkValue("final errors", 32'd3, errSeen);

		$display("Done: %0d errors, %0d frame errors, %0d overruns", errors, errSeen, ovrSeen);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
source/ps2Pkg.sv
source/ps2LineFilter.sv
source/ps2Deframer.sv
source/scanDecoder.sv
source/ps2Receiver.sv
tb/ps2ReceiverTb.sv

/* build.sh */
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ps2ReceiverTb \
	-f build.f --Mdir obj_dir -o simv > build.log 2>&1 \
	&& ./obj_dir/simv > sim.log 2>&1 \
	; grep -q "^TEST PASS$" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see build.log and sim.log"; exit 1; }
